// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing
TOP       = pipe_core_tb
FILELIST  = pipe_core.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/clk_gen.sv ====
`default_nettype none

module clk_gen (
	output logic o_clk,
	output logic o_rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;
	end

	// reset held low over the first two rising edges.
	initial begin
		o_rst_n = 1'b0;
		repeat (2) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== dv/pipe_core_tb.sv ====
`default_nettype none

module pipe_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          PROG_WORDS   = 64;
	localparam int          DMEM_WORDS   = 64;
	localparam int          WAIT_LIMIT   = 300;
	localparam int          DRAIN_CYCLES = 8;
	localparam logic [31:0] SEED         = 32'd64142;

	// instruction kinds of the program descriptors.
	localparam int K_ADD  = 0;
	localparam int K_SUB  = 1;
	localparam int K_AND  = 2;
	localparam int K_OR   = 3;
	localparam int K_ADDI = 4;
	localparam int K_LW   = 5;
	localparam int K_SW   = 6;
	localparam int K_BEQ  = 7;

	logic                clk;
	logic                gen_rst_n;
	logic                test_rst_n;
	logic                rst_n;
	pipe_pkg::word_t     imem_addr;
	pipe_pkg::word_t     imem_data;
	logic                wb_valid;
	pipe_pkg::reg_addr_t wb_rd;
	pipe_pkg::word_t     wb_data;

	pipe_pkg::word_t prog [PROG_WORDS];
	int              d_kind [PROG_WORDS];
	int              d_rd [PROG_WORDS];
	int              d_rs1 [PROG_WORDS];
	int              d_rs2 [PROG_WORDS];
	int              d_imm [PROG_WORDS];
	int              prog_len;

	pipe_pkg::reg_addr_t exp_rd [$];
	pipe_pkg::word_t     exp_data [$];
	int                  exp_cycle [$];
	pipe_pkg::reg_addr_t got_rd [$];
	pipe_pkg::word_t     got_data [$];
	int                  got_cycle [$];

	int cycle = 0;
	int start_cycle;

	clk_gen u_clk_gen (
		.o_clk   (clk),
		.o_rst_n (gen_rst_n)
	);

	assign rst_n = gen_rst_n && test_rst_n;

	// fetches past the array read as an all-zero no-op.
	assign imem_data = (imem_addr[31:8] == '0) ? prog[imem_addr[7:2]] : '0;

	pipe_core #(
		.RESET_PC   (32'h0),
		.DMEM_WORDS (DMEM_WORDS)
	) uut (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.o_imem_addr (imem_addr),
		.i_imem_data (imem_data),
		.o_wb_valid  (wb_valid),
		.o_wb_rd     (wb_rd),
		.o_wb_data   (wb_data)
	);

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// the commit trace is sampled mid-cycle.
	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			got_rd.push_back(wb_rd);
			got_data.push_back(wb_data);
			got_cycle.push_back(cycle);
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic compare_reg(input pipe_pkg::reg_addr_t got, input pipe_pkg::reg_addr_t exp,
	                           input string what);
		if (got !== exp)
			abort_run($sformatf("FAIL %0t: %s got x%0d, expected x%0d", $time, what, got, exp));
	endtask

	task automatic compare_word(input pipe_pkg::word_t got, input pipe_pkg::word_t exp,
	                            input string what);
		if (got !== exp)
			abort_run($sformatf("FAIL %0t: %s got 0x%08h, expected 0x%08h", $time, what, got, exp));
	endtask

	task automatic compare_cycle(input int got, input int exp, input string what);
		if (got != exp)
			abort_run($sformatf("FAIL %0t: %s got %0d, expected %0d", $time, what, got, exp));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic pipe_pkg::word_t encode_r(input isa_pkg::funct7_t f7,
	                                             input isa_pkg::funct3_t f3,
	                                             input pipe_pkg::reg_addr_t rd,
	                                             input pipe_pkg::reg_addr_t rs1,
	                                             input pipe_pkg::reg_addr_t rs2);
		return {f7, rs2, rs1, f3, rd, isa_pkg::OP_RTYPE};
	endfunction

	function automatic pipe_pkg::word_t encode_i(input isa_pkg::opcode_t op,
	                                             input isa_pkg::funct3_t f3,
	                                             input pipe_pkg::reg_addr_t rd,
	                                             input pipe_pkg::reg_addr_t rs1,
	                                             input pipe_pkg::word_t imm);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic pipe_pkg::word_t encode_s(input pipe_pkg::reg_addr_t rs1,
	                                             input pipe_pkg::reg_addr_t rs2,
	                                             input pipe_pkg::word_t imm);
		return {imm[11:5], rs2, rs1, isa_pkg::F3_WORD, imm[4:0], isa_pkg::OP_STORE};
	endfunction

	function automatic pipe_pkg::word_t encode_b(input pipe_pkg::reg_addr_t rs1,
	                                             input pipe_pkg::reg_addr_t rs2,
	                                             input pipe_pkg::word_t imm);
		return {imm[12], imm[10:5], rs2, rs1, isa_pkg::F3_BEQ, imm[4:1], imm[11],
		        isa_pkg::OP_BRANCH};
	endfunction

	task automatic clear_program();
		for (int i = 0; i < PROG_WORDS; i++) begin
			prog[i]   = '0;
			d_kind[i] = K_ADD;
			d_rd[i]   = 0;
			d_rs1[i]  = 0;
			d_rs2[i]  = 0;
			d_imm[i]  = 0;
		end
		prog_len = 0;
	endtask

	// appends one instruction and keeps unused register fields at x0.
	task automatic emit(input int kind, input int rd, input int rs1, input int rs2, input int imm);
		pipe_pkg::reg_addr_t a_rd;
		pipe_pkg::reg_addr_t a_rs1;
		pipe_pkg::reg_addr_t a_rs2;
		pipe_pkg::word_t     imm_w;
		pipe_pkg::word_t     w;
		if (prog_len >= PROG_WORDS)
			abort_run("program does not fit in the instruction array");
		a_rd  = (kind == K_SW || kind == K_BEQ) ? '0 : pipe_pkg::reg_addr_t'(rd);
		a_rs1 = pipe_pkg::reg_addr_t'(rs1);
		a_rs2 = (kind == K_ADDI || kind == K_LW) ? '0 : pipe_pkg::reg_addr_t'(rs2);
		imm_w = pipe_pkg::word_t'(imm);
		case (kind)
			K_ADD:   w = encode_r(isa_pkg::F7_BASE, isa_pkg::F3_ADD_SUB, a_rd, a_rs1, a_rs2);
			K_SUB:   w = encode_r(isa_pkg::F7_SUB, isa_pkg::F3_ADD_SUB, a_rd, a_rs1, a_rs2);
			K_AND:   w = encode_r(isa_pkg::F7_BASE, isa_pkg::F3_AND, a_rd, a_rs1, a_rs2);
			K_OR:    w = encode_r(isa_pkg::F7_BASE, isa_pkg::F3_OR, a_rd, a_rs1, a_rs2);
			K_ADDI:  w = encode_i(isa_pkg::OP_IMM, isa_pkg::F3_ADD_SUB, a_rd, a_rs1, imm_w);
			K_LW:    w = encode_i(isa_pkg::OP_LOAD, isa_pkg::F3_WORD, a_rd, a_rs1, imm_w);
			K_SW:    w = encode_s(a_rs1, a_rs2, imm_w);
			default: w = encode_b(a_rs1, a_rs2, imm_w);
		endcase
		prog[prog_len]   = w;
		d_kind[prog_len] = kind;
		d_rd[prog_len]   = int'(a_rd);
		d_rs1[prog_len]  = int'(a_rs1);
		d_rs2[prog_len]  = int'(a_rs2);
		d_imm[prog_len]  = imm;
		prog_len++;
	endtask

	// the in-order model counts commit cycles from the fetch of the first instruction.
	function automatic void run_model();
		pipe_pkg::word_t x [32];
		pipe_pkg::word_t dmem [DMEM_WORDS];
		pipe_pkg::word_t a;
		pipe_pkg::word_t b;
		pipe_pkg::word_t res;
		pipe_pkg::word_t addr;
		int              i;
		int              slot;
		int              steps;
		int              load_rd;
		logic            writes;
		logic            taken;
		exp_rd.delete();
		exp_data.delete();
		exp_cycle.delete();
		for (int r = 0; r < 32; r++) begin
			x[r] = '0;
		end
		i = 0;
		slot = 0;
		steps = 0;
		load_rd = 0;
		while (i >= 0 && i < prog_len && steps < 1000) begin
			a = x[d_rs1[i]];
			b = x[d_rs2[i]];
			// a load feeding the very next instruction costs one bubble.
			if (load_rd != 0 && (load_rd == d_rs1[i] || load_rd == d_rs2[i]))
				slot++;
			writes = 1'b1;
			taken  = 1'b0;
			res    = '0;
			addr   = a + pipe_pkg::word_t'(d_imm[i]);
			case (d_kind[i])
				K_ADD:  res = a + b;
				K_SUB:  res = a - b;
				K_AND:  res = a & b;
				K_OR:   res = a | b;
				K_ADDI: res = addr;
				K_LW:   res = dmem[int'((addr >> 2) % DMEM_WORDS)];
				K_SW: begin
					dmem[int'((addr >> 2) % DMEM_WORDS)] = b;
					writes = 1'b0;
				end
				default: begin
					taken  = (a == b);
					writes = 1'b0;
				end
			endcase
			if (writes && d_rd[i] != 0) begin
				x[d_rd[i]] = res;
				exp_rd.push_back(pipe_pkg::reg_addr_t'(d_rd[i]));
				exp_data.push_back(res);
				exp_cycle.push_back(slot + 4);
			end
			load_rd = (d_kind[i] == K_LW) ? d_rd[i] : 0;
			// a taken branch discards two younger fetches.
			if (taken) begin
				i = i + d_imm[i] / 4;
				slot = slot + 3;
			end else begin
				i++;
				slot++;
			end
			steps++;
		end
	endfunction

	task automatic assert_reset();
		@(posedge clk);
		test_rst_n <= 1'b0;
		clear_program();
	endtask

	task automatic release_reset();
		repeat (2) @(posedge clk);
		got_rd.delete();
		got_data.delete();
		got_cycle.delete();
		test_rst_n <= 1'b1;
		@(negedge clk);
		start_cycle = cycle;
	endtask

	task automatic check_trace(input string name);
		int waited;
		int i;
		run_model();
		waited = 0;
		while (got_rd.size() < exp_rd.size()) begin
			if (waited >= WAIT_LIMIT)
				abort_run($sformatf("%s: timed out after %0d cycles with %0d of %0d writes seen",
				                    name, waited, got_rd.size(), exp_rd.size()));
			@(negedge clk);
			waited++;
		end
		// idle cycles catch writes that should never appear.
		repeat (DRAIN_CYCLES) @(negedge clk);
		if (got_rd.size() != exp_rd.size())
			abort_run($sformatf("%s: saw %0d register writes where %0d were expected",
			                    name, got_rd.size(), exp_rd.size()));
		for (i = 0; i < exp_rd.size(); i++) begin
			compare_reg(got_rd[i], exp_rd[i], $sformatf("%s write %0d rd", name, i));
			compare_word(got_data[i], exp_data[i], $sformatf("%s write %0d data", name, i));
			compare_cycle(got_cycle[i] - start_cycle, exp_cycle[i],
			              $sformatf("%s write %0d commit cycle", name, i));
		end
		$display("%s: %0d register writes match", name, exp_rd.size());
	endtask

	task automatic alu_chain_forwarding();
		assert_reset();
		emit(K_ADDI, 1, 0, 0, 37);
		emit(K_ADD, 2, 1, 1, 0);
		emit(K_SUB, 3, 2, 1, 0);
		emit(K_AND, 4, 3, 2, 0);
		emit(K_OR, 5, 4, 3, 0);
		// both later stages hold x6 and the younger value must reach x7.
		emit(K_ADDI, 6, 0, 0, 100);
		emit(K_ADDI, 6, 0, 0, -5);
		emit(K_ADD, 7, 6, 6, 0);
		release_reset();
		check_trace("alu chain");
	endtask

	task automatic load_use_stall();
		assert_reset();
		emit(K_ADDI, 1, 0, 0, 85);
		emit(K_ADDI, 2, 0, 0, 8);
		emit(K_SW, 0, 2, 1, 4);
		emit(K_LW, 3, 2, 0, 4);
		emit(K_ADD, 4, 3, 1, 0);
		emit(K_LW, 5, 2, 0, 4);
		emit(K_ADD, 6, 1, 1, 0);
		emit(K_ADD, 7, 5, 5, 0);
		release_reset();
		check_trace("load use");
		compare_cycle(got_cycle[3] - got_cycle[2], 2, "dependent add after load, gap");
		compare_cycle(got_cycle[5] - got_cycle[4], 1, "independent add after load, gap");
	endtask

	task automatic branch_skip();
		assert_reset();
		emit(K_ADDI, 1, 0, 0, 9);
		emit(K_ADDI, 2, 0, 0, 9);
		emit(K_BEQ, 0, 1, 2, 12);
		emit(K_ADDI, 3, 0, 0, 1);
		emit(K_ADDI, 4, 0, 0, 2);
		emit(K_ADDI, 5, 0, 0, 3);
		emit(K_BEQ, 0, 1, 5, 12);
		emit(K_ADDI, 6, 0, 0, 4);
		emit(K_ADDI, 7, 0, 0, 5);
		release_reset();
		check_trace("branch");
	endtask

	task automatic zero_register_writes();
		assert_reset();
		emit(K_ADDI, 0, 0, 0, 5);
		emit(K_ADDI, 1, 0, 0, 11);
		emit(K_ADD, 0, 1, 1, 0);
		emit(K_ADDI, 2, 0, 0, 7);
		emit(K_OR, 3, 0, 0, 0);
		emit(K_SUB, 4, 1, 0, 0);
		release_reset();
		check_trace("register zero");
	endtask

	task automatic random_alu_program();
		logic [31:0] rng;
		int          n;
		rng = SEED;
		assert_reset();
		for (n = 0; n < 40; n++) begin
			rng = xorshift(rng);
			emit(int'(rng % 32'd5), 1 + int'((rng >> 3) % 32'd7), 1 + int'((rng >> 6) % 32'd7),
			     1 + int'((rng >> 9) % 32'd7), int'(rng[31:20]) - 2048);
		end
		release_reset();
		check_trace("random program");
	endtask

	initial begin
		test_rst_n = 1'b0;
		clear_program();
		alu_chain_forwarding();
		load_use_stall();
		branch_skip();
		zero_register_writes();
		random_alu_program();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pipe_core.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/regfile.sv
source/decoder.sv
source/hazard.sv
source/data_mem.sv
source/pipe_core.sv
dv/clk_gen.sv
dv/pipe_core_tb.sv

// ==== source/data_mem.sv ====
`default_nettype none

module data_mem #(
	parameter int DMEM_WORDS = 64
) (
	input  logic            i_clk,
	input  pipe_pkg::word_t i_addr,
	input  pipe_pkg::word_t i_wdata,
	input  logic            i_wren,
	output pipe_pkg::word_t o_rdata
);

	// DMEM_WORDS is a power of two, so the index wraps by truncation.
	localparam int INDEX_W = $clog2(DMEM_WORDS);

	pipe_pkg::word_t mem [DMEM_WORDS];

	logic [INDEX_W-1:0] index;

	// byte offset dropped.
	assign index = i_addr[INDEX_W+1:2];

	always_ff @(posedge i_clk) begin
		if (i_wren) begin
			mem[index] <= i_wdata;
		end
	end

	assign o_rdata = mem[index];

endmodule

`default_nettype wire

// ==== source/decoder.sv ====
`default_nettype none

module decoder (
	input  pipe_pkg::word_t     i_instr,
	output pipe_pkg::reg_addr_t o_rs1_addr,
	output pipe_pkg::reg_addr_t o_rs2_addr,
	output pipe_pkg::reg_addr_t o_rd_addr,
	output pipe_pkg::word_t     o_imm,
	output isa_pkg::alu_op_t    o_alu_op,
	output logic                o_alu_src_imm,
	output logic                o_rd_wren,
	output logic                o_mem_wren,
	output logic                o_branch,
	output pipe_pkg::wb_sel_t   o_wb_sel
);

	isa_pkg::opcode_t opcode;
	isa_pkg::funct3_t funct3;
	isa_pkg::funct7_t funct7;
	pipe_pkg::word_t  imm_i;
	pipe_pkg::word_t  imm_s;
	pipe_pkg::word_t  imm_b;
	logic             r_legal;
	logic             use_rs1;
	logic             use_rs2;

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];

	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
	assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
	                i_instr[11:8], 1'b0};

	// only add, sub, and, or.
	assign r_legal = ((funct7 == isa_pkg::F7_BASE) &&
	                  ((funct3 == isa_pkg::F3_ADD_SUB) || (funct3 == isa_pkg::F3_AND) ||
	                   (funct3 == isa_pkg::F3_OR))) ||
	                 ((funct7 == isa_pkg::F7_SUB) && (funct3 == isa_pkg::F3_ADD_SUB));

	always_comb begin
		o_imm         = imm_i;
		o_alu_op      = isa_pkg::ALU_ADD;
		o_alu_src_imm = 1'b0;
		o_rd_wren     = 1'b0;
		o_mem_wren    = 1'b0;
		o_branch      = 1'b0;
		o_wb_sel      = pipe_pkg::WB_ALU;
		use_rs1       = 1'b0;
		use_rs2       = 1'b0;
		case (opcode)
			isa_pkg::OP_RTYPE: begin
				if (r_legal) begin
					o_rd_wren = 1'b1;
					use_rs1   = 1'b1;
					use_rs2   = 1'b1;
					case (funct3)
						isa_pkg::F3_ADD_SUB:
							o_alu_op = (funct7 == isa_pkg::F7_SUB) ? isa_pkg::ALU_SUB :
							                                         isa_pkg::ALU_ADD;
						isa_pkg::F3_AND: o_alu_op = isa_pkg::ALU_AND;
						default:         o_alu_op = isa_pkg::ALU_OR;
					endcase
				end
			end
			isa_pkg::OP_IMM: begin
				if (funct3 == isa_pkg::F3_ADD_SUB) begin
					o_alu_src_imm = 1'b1;
					o_rd_wren     = 1'b1;
					use_rs1       = 1'b1;
				end
			end
			isa_pkg::OP_LOAD: begin
				if (funct3 == isa_pkg::F3_WORD) begin
					o_alu_src_imm = 1'b1;
					o_rd_wren     = 1'b1;
					o_wb_sel      = pipe_pkg::WB_MEM;
					use_rs1       = 1'b1;
				end
			end
			isa_pkg::OP_STORE: begin
				if (funct3 == isa_pkg::F3_WORD) begin
					o_imm         = imm_s;
					o_alu_src_imm = 1'b1;
					o_mem_wren    = 1'b1;
					use_rs1       = 1'b1;
					use_rs2       = 1'b1;
				end
			end
			isa_pkg::OP_BRANCH: begin
				if (funct3 == isa_pkg::F3_BEQ) begin
					o_imm    = imm_b;
					o_alu_op = isa_pkg::ALU_SUB;
					o_branch = 1'b1;
					use_rs1  = 1'b1;
					use_rs2  = 1'b1;
				end
			end
			default: ;
		endcase
	end

	// unused fields read as x0 so they never raise a hazard.
	assign o_rs1_addr = use_rs1   ? i_instr[19:15] : '0;
	assign o_rs2_addr = use_rs2   ? i_instr[24:20] : '0;
	assign o_rd_addr  = o_rd_wren ? i_instr[11:7]  : '0;

endmodule

`default_nettype wire

// ==== source/hazard.sv ====
`default_nettype none

module hazard (
	input  pipe_pkg::reg_addr_t i_rs1_addr_decode,
	input  pipe_pkg::reg_addr_t i_rs2_addr_decode,
	input  pipe_pkg::reg_addr_t i_rs1_addr_execute,
	input  pipe_pkg::reg_addr_t i_rs2_addr_execute,
	input  pipe_pkg::reg_addr_t i_rd_addr_execute,
	input  pipe_pkg::reg_addr_t i_rd_addr_memory,
	input  pipe_pkg::reg_addr_t i_rd_addr_writeback,
	input  logic                i_pc_sel,
	input  logic                i_rd_wren_memory,
	input  logic                i_rd_wren_writeback,
	input  pipe_pkg::wb_sel_t   i_wb_sel_execute,
	output pipe_pkg::fwd_sel_t  o_forward_a_execute,
	output pipe_pkg::fwd_sel_t  o_forward_b_execute,
	output logic                o_stall_fetch,
	output logic                o_stall_decode,
	output logic                o_flush_decode,
	output logic                o_flush_execute
);

	logic load_use;

	// memory stage holds the newer value, so it is checked first.
	function automatic pipe_pkg::fwd_sel_t select_source(
		input pipe_pkg::reg_addr_t src,
		input pipe_pkg::reg_addr_t rd_mem,
		input logic                wren_mem,
		input pipe_pkg::reg_addr_t rd_wb,
		input logic                wren_wb
	);
		if (wren_mem && (rd_mem != '0) && (rd_mem == src))
			return pipe_pkg::FWD_MEM;
		if (wren_wb && (rd_wb != '0) && (rd_wb == src))
			return pipe_pkg::FWD_WB;
		return pipe_pkg::FWD_NONE;
	endfunction

	assign o_forward_a_execute = select_source(i_rs1_addr_execute,
	                                           i_rd_addr_memory, i_rd_wren_memory,
	                                           i_rd_addr_writeback, i_rd_wren_writeback);
	assign o_forward_b_execute = select_source(i_rs2_addr_execute,
	                                           i_rd_addr_memory, i_rd_wren_memory,
	                                           i_rd_addr_writeback, i_rd_wren_writeback);

	// load in execute feeding the instruction in decode.
	assign load_use = i_wb_sel_execute[pipe_pkg::WB_LOAD_BIT] && (i_rd_addr_execute != '0) &&
	                  ((i_rd_addr_execute == i_rs1_addr_decode) ||
	                   (i_rd_addr_execute == i_rs2_addr_decode));

	// a taken branch discards the younger work anyway.
	assign o_stall_fetch   = load_use && !i_pc_sel;
	assign o_stall_decode  = load_use && !i_pc_sel;
	assign o_flush_decode  = i_pc_sel;
	assign o_flush_execute = load_use || i_pc_sel;

endmodule

`default_nettype wire

// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;
	typedef logic [2:0] alu_op_t;

	// major opcodes of the supported subset.
	localparam opcode_t OP_RTYPE  = 7'b0110011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;

	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_AND     = 3'b111;
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_WORD    = 3'b010;
	localparam funct3_t F3_BEQ     = 3'b000;

	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_SUB  = 7'b0100000;

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR  = 3'd3;

endpackage

`default_nettype wire

// ==== source/pipe_core.sv ====
`default_nettype none

module pipe_core #(
	parameter pipe_pkg::word_t RESET_PC   = '0,
	parameter int              DMEM_WORDS = 64
) (
	input  logic                i_clk,
	input  logic                i_rst_n,
	output pipe_pkg::word_t     o_imem_addr,
	input  pipe_pkg::word_t     i_imem_data,
	output logic                o_wb_valid,
	output pipe_pkg::reg_addr_t o_wb_rd,
	output pipe_pkg::word_t     o_wb_data
);

	pipe_pkg::word_t     pc_f;
	pipe_pkg::word_t     pc_next;

	pipe_pkg::word_t     pc_d;
	pipe_pkg::word_t     instr_d;
	pipe_pkg::reg_addr_t rs1_addr_d;
	pipe_pkg::reg_addr_t rs2_addr_d;
	pipe_pkg::reg_addr_t rd_addr_d;
	pipe_pkg::word_t     imm_d;
	pipe_pkg::word_t     rs1_data_d;
	pipe_pkg::word_t     rs2_data_d;
	isa_pkg::alu_op_t    alu_op_d;
	logic                alu_src_imm_d;
	logic                rd_wren_d;
	logic                mem_wren_d;
	logic                branch_d;
	pipe_pkg::wb_sel_t   wb_sel_d;

	pipe_pkg::word_t     pc_e;
	pipe_pkg::word_t     rs1_data_e;
	pipe_pkg::word_t     rs2_data_e;
	pipe_pkg::word_t     imm_e;
	pipe_pkg::reg_addr_t rs1_addr_e;
	pipe_pkg::reg_addr_t rs2_addr_e;
	pipe_pkg::reg_addr_t rd_addr_e;
	isa_pkg::alu_op_t    alu_op_e;
	logic                alu_src_imm_e;
	logic                rd_wren_e;
	logic                mem_wren_e;
	logic                branch_e;
	pipe_pkg::wb_sel_t   wb_sel_e;
	pipe_pkg::fwd_sel_t  forward_a_e;
	pipe_pkg::fwd_sel_t  forward_b_e;
	pipe_pkg::word_t     src_a_e;
	pipe_pkg::word_t     src_b_e;
	pipe_pkg::word_t     alu_in_b_e;
	pipe_pkg::word_t     alu_result_e;
	pipe_pkg::word_t     branch_target_e;
	logic                pc_sel_e;

	pipe_pkg::word_t     alu_result_m;
	pipe_pkg::word_t     store_data_m;
	pipe_pkg::word_t     mem_rdata_m;
	pipe_pkg::reg_addr_t rd_addr_m;
	logic                rd_wren_m;
	logic                mem_wren_m;
	pipe_pkg::wb_sel_t   wb_sel_m;

	pipe_pkg::word_t     alu_result_w;
	pipe_pkg::word_t     mem_data_w;
	pipe_pkg::word_t     wb_data_w;
	pipe_pkg::reg_addr_t rd_addr_w;
	logic                rd_wren_w;
	pipe_pkg::wb_sel_t   wb_sel_w;

	logic                stall_fetch;
	logic                stall_decode;
	logic                flush_decode;
	logic                flush_execute;

	function automatic pipe_pkg::word_t forward_mux(
		input pipe_pkg::fwd_sel_t sel,
		input pipe_pkg::word_t    reg_value,
		input pipe_pkg::word_t    mem_value,
		input pipe_pkg::word_t    wb_value
	);
		case (sel)
			pipe_pkg::FWD_MEM: return mem_value;
			pipe_pkg::FWD_WB:  return wb_value;
			default:           return reg_value;
		endcase
	endfunction

	// fetch.
	assign o_imem_addr = pc_f;
	assign pc_next     = pc_sel_e    ? branch_target_e :
	                     stall_fetch ? pc_f : pc_f + 32'd4;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n)
			pc_f <= RESET_PC;
		else
			pc_f <= pc_next;
	end

	// an all-zero word decodes as a bubble.
	always_ff @(posedge i_clk) begin
		if (!i_rst_n || flush_decode)
			instr_d <= '0;
		else if (!stall_decode)
			instr_d <= i_imem_data;
	end

	always_ff @(posedge i_clk) begin
		if (!stall_decode)
			pc_d <= pc_f;
	end

	// decode.
	decoder u_decoder (
		.i_instr       (instr_d),
		.o_rs1_addr    (rs1_addr_d),
		.o_rs2_addr    (rs2_addr_d),
		.o_rd_addr     (rd_addr_d),
		.o_imm         (imm_d),
		.o_alu_op      (alu_op_d),
		.o_alu_src_imm (alu_src_imm_d),
		.o_rd_wren     (rd_wren_d),
		.o_mem_wren    (mem_wren_d),
		.o_branch      (branch_d),
		.o_wb_sel      (wb_sel_d)
	);

	regfile u_regfile (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_rs1_addr (rs1_addr_d),
		.i_rs2_addr (rs2_addr_d),
		.i_rd_addr  (rd_addr_w),
		.i_rd_data  (wb_data_w),
		.i_rd_wren  (o_wb_valid),
		.o_rs1_data (rs1_data_d),
		.o_rs2_data (rs2_data_d)
	);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n || flush_execute) begin
			rd_wren_e  <= 1'b0;
			mem_wren_e <= 1'b0;
			branch_e   <= 1'b0;
			wb_sel_e   <= pipe_pkg::WB_ALU;
		end else begin
			rd_wren_e  <= rd_wren_d;
			mem_wren_e <= mem_wren_d;
			branch_e   <= branch_d;
			wb_sel_e   <= wb_sel_d;
		end
	end

	always_ff @(posedge i_clk) begin
		pc_e          <= pc_d;
		rs1_data_e    <= rs1_data_d;
		rs2_data_e    <= rs2_data_d;
		imm_e         <= imm_d;
		rs1_addr_e    <= rs1_addr_d;
		rs2_addr_e    <= rs2_addr_d;
		rd_addr_e     <= rd_addr_d;
		alu_op_e      <= alu_op_d;
		alu_src_imm_e <= alu_src_imm_d;
	end

	// execute.
	// loads never forward from the memory stage because the load-use stall covers them.
	assign src_a_e    = forward_mux(forward_a_e, rs1_data_e, alu_result_m, wb_data_w);
	assign src_b_e    = forward_mux(forward_b_e, rs2_data_e, alu_result_m, wb_data_w);
	assign alu_in_b_e = alu_src_imm_e ? imm_e : src_b_e;

	always_comb begin
		case (alu_op_e)
			isa_pkg::ALU_SUB: alu_result_e = src_a_e - alu_in_b_e;
			isa_pkg::ALU_AND: alu_result_e = src_a_e & alu_in_b_e;
			isa_pkg::ALU_OR:  alu_result_e = src_a_e | alu_in_b_e;
			default:          alu_result_e = src_a_e + alu_in_b_e;
		endcase
	end

	assign branch_target_e = pc_e + imm_e;
	assign pc_sel_e        = branch_e && (src_a_e == src_b_e);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			rd_wren_m  <= 1'b0;
			mem_wren_m <= 1'b0;
			wb_sel_m   <= pipe_pkg::WB_ALU;
		end else begin
			rd_wren_m  <= rd_wren_e;
			mem_wren_m <= mem_wren_e;
			wb_sel_m   <= wb_sel_e;
		end
	end

	always_ff @(posedge i_clk) begin
		alu_result_m <= alu_result_e;
		store_data_m <= src_b_e;
		rd_addr_m    <= rd_addr_e;
	end

	// memory.
	data_mem #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_data_mem (
		.i_clk   (i_clk),
		.i_addr  (alu_result_m),
		.i_wdata (store_data_m),
		.i_wren  (mem_wren_m),
		.o_rdata (mem_rdata_m)
	);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			rd_wren_w <= 1'b0;
			wb_sel_w  <= pipe_pkg::WB_ALU;
		end else begin
			rd_wren_w <= rd_wren_m;
			wb_sel_w  <= wb_sel_m;
		end
	end

	always_ff @(posedge i_clk) begin
		alu_result_w <= alu_result_m;
		mem_data_w   <= mem_rdata_m;
		rd_addr_w    <= rd_addr_m;
	end

	// writeback.
	always_comb begin
		case (wb_sel_w)
			pipe_pkg::WB_MEM: wb_data_w = mem_data_w;
			default:          wb_data_w = alu_result_w;
		endcase
	end

	assign o_wb_valid = rd_wren_w && (rd_addr_w != '0);
	assign o_wb_rd    = rd_addr_w;
	assign o_wb_data  = wb_data_w;

	hazard u_hazard (
		.i_rs1_addr_decode    (rs1_addr_d),
		.i_rs2_addr_decode    (rs2_addr_d),
		.i_rs1_addr_execute   (rs1_addr_e),
		.i_rs2_addr_execute   (rs2_addr_e),
		.i_rd_addr_execute    (rd_addr_e),
		.i_rd_addr_memory     (rd_addr_m),
		.i_rd_addr_writeback  (rd_addr_w),
		.i_pc_sel             (pc_sel_e),
		.i_rd_wren_memory     (rd_wren_m),
		.i_rd_wren_writeback  (rd_wren_w),
		.i_wb_sel_execute     (wb_sel_e),
		.o_forward_a_execute  (forward_a_e),
		.o_forward_b_execute  (forward_b_e),
		.o_stall_fetch        (stall_fetch),
		.o_stall_decode       (stall_decode),
		.o_flush_decode       (flush_decode),
		.o_flush_execute      (flush_execute)
	);

endmodule

`default_nettype wire

// ==== source/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

	localparam int XLEN     = 32;
	localparam int REG_BITS = 5;

	// data word, register value or byte address.
	typedef logic [XLEN-1:0] word_t;

	// architectural register index.
	typedef logic [REG_BITS-1:0] reg_addr_t;

	// operand source for the execute stage.
	typedef logic [1:0] fwd_sel_t;

	localparam fwd_sel_t FWD_NONE = 2'b00;
	localparam fwd_sel_t FWD_MEM  = 2'b01;
	localparam fwd_sel_t FWD_WB   = 2'b10;

	// writeback source, bit 1 marks a load.
	typedef logic [1:0] wb_sel_t;

	localparam wb_sel_t WB_ALU = 2'b00;
	localparam wb_sel_t WB_PC4 = 2'b01;
	localparam wb_sel_t WB_MEM = 2'b10;

	// position of the load flag inside wb_sel_t.
	localparam int WB_LOAD_BIT = 1;

endpackage

`default_nettype wire

// ==== source/regfile.sv ====
`default_nettype none

module regfile (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  pipe_pkg::reg_addr_t i_rs1_addr,
	input  pipe_pkg::reg_addr_t i_rs2_addr,
	input  pipe_pkg::reg_addr_t i_rd_addr,
	input  pipe_pkg::word_t     i_rd_data,
	input  logic                i_rd_wren,
	output pipe_pkg::word_t     o_rs1_data,
	output pipe_pkg::word_t     o_rs2_data
);

	// x0 has no storage.
	pipe_pkg::word_t regs [1:31];

	logic rs1_bypass;
	logic rs2_bypass;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_rd_wren && (i_rd_addr != '0)) begin
			regs[i_rd_addr] <= i_rd_data;
		end
	end

	// a write in this cycle is seen by decode in the same cycle.
	assign rs1_bypass = i_rd_wren && (i_rd_addr == i_rs1_addr);
	assign rs2_bypass = i_rd_wren && (i_rd_addr == i_rs2_addr);

	assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
	                    rs1_bypass         ? i_rd_data :
	                                         regs[i_rs1_addr];

	assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
	                    rs2_bypass         ? i_rd_data :
	                                         regs[i_rs2_addr];

endmodule

`default_nettype wire
